//--- udp_tx.f
+incdir+include
design/udp_tx_pkg.sv
design/udp_byte_if.sv
design/udp_session_ctrl.sv
design/udp_header_gen.sv
design/udp_payload_fetch.sv
design/udp_frame_merge.sv
design/udp_tx_top.sv
tb/udp_tx_assert.sv
tb/udp_tx_tb.sv

//--- run_sim.sh
#!/bin/sh
verilator --binary --timing --assert --top-module udp_tx_tb -f udp_tx.f -o udp_tx_sim \
    && { ./obj_dir/udp_tx_sim > sim.log 2>&1; cat sim.log; } \
    && grep -q "Test completed successfully" sim.log \
    && echo "PASS" \
    || { echo "FAIL"; exit 1; }

//--- tb/udp_tx_trace.txt
# kind len index gap payload bytes, all hex; gap is idle cycles between out_credit pulses
# kind 0 steady source, 1 random source stalls, 2 second trig during the frame
0 4 0001 0 de ad be ef
0 0 0002 0
0 10 0103 1 00 11 22 33 44 55 66 77 88 99 aa bb cc dd ee ff
1 8 1234 3 5a a5 3c c3 0f f0 69 96
1 14 0a05 6 01 02 03 04 05 06 07 08 09 0a 0b 0c 0d 0e 0f 10 11 12 13 14
2 6 0006 0 c0 ff ee 00 ba be
1 0 ffff 5
0 1 8000 2 7f
2 c 0009 4 10 20 30 40 50 60 70 80 90 a0 b0 c0
1 18 7e7f 2 80 81 82 83 84 85 86 87 88 89 8a 8b 8c 8d 8e 8f 90 91 92 93 94 95 96 97
0 9 4242 0 fe dc ba 98 76 54 32 10 01

//--- tb/udp_tx_tb.sv
`timescale 1ns/1ns
`include "udp_tx_settings.svh"

module udp_tx_tb;

    logic        rgmii_clk;
    logic        arp_rstn;
    logic        trig;
    logic [15:0] index;
    logic [15:0] tx_data_len;
    logic        tx_read_en;
    logic        tx_valid = 1'b0;
    logic [7:0]  tx_data = 8'h00;
    logic        arp_req;
    logic        arp_found;
    logic        connected;
    logic        out_valid;
    logic [7:0]  out_data;
    logic        out_last;
    logic        out_credit;

    // Trace contents, payload bytes in one flat list
    int          t_kind[$];
    int          t_len[$];
    int          t_idx[$];
    int          t_gap[$];
    int          t_off[$];
    logic [7:0]  t_bytes[$];

    // Source model, the main process only sets up each frame
    logic [7:0]  src_bytes[$];
    bit          stall_en = 1'b0;
    int          src_base = 0;
    int          src_len = 0;
    int          src_taken = 0;
    int          read_cnt = 0;
    int          overrun_cnt = 0;
    logic [31:0] rng = 32'hc3f2f7d7;

    int          errors = 0;
    int          granted = 0;
    int          delivered = 0;
    int          gap_cnt = 0;
    int          test_cnt = 0;
    int          bad_cnt = 0;
    int          limit_cycles = 0;
    bit          trace_ok;
    int          n;

    udp_tx_top dut_i (
        .rgmii_clk  (rgmii_clk),
        .arp_rstn   (arp_rstn),
        .trig       (trig),
        .index      (index),
        .tx_data_len(tx_data_len),
        .tx_read_en (tx_read_en),
        .tx_valid   (tx_valid),
        .tx_data    (tx_data),
        .arp_req    (arp_req),
        .arp_found  (arp_found),
        .connected  (connected),
        .out_valid  (out_valid),
        .out_data   (out_data),
        .out_last   (out_last),
        .out_credit (out_credit)
    );

    initial begin
        rgmii_clk = 1'b0;
        forever #5 rgmii_clk = ~rgmii_clk;
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // Answers a request in the same cycle unless a stall is drawn
    always @(negedge rgmii_clk) begin
        if (tx_read_en === 1'b1) begin
            read_cnt = read_cnt + 1;
            rng = lcg_next(rng);
            if (stall_en && rng[31:29] < 3'd3) begin
                tx_valid = 1'b0;
            end else if (src_taken - src_base >= src_len) begin
                tx_valid = 1'b0;
                overrun_cnt = overrun_cnt + 1;
            end else begin
                tx_valid = 1'b1;
                tx_data = src_bytes[src_taken - src_base];
                src_taken = src_taken + 1;
            end
        end else begin
            tx_valid = 1'b0;
        end
    end

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("error %s: got 0x%0h, expected 0x%0h", name, got, exp);
            errors++;
        end
    endtask

    // Pulse out_credit every gap+1 cycles, never past the credit ceiling
    task automatic grant_credit(input int gap);
        if (gap_cnt >= gap && granted - delivered < `UDP_CREDIT_MAX) begin
            out_credit = 1'b1;
            granted++;
            gap_cnt = 0;
        end else begin
            out_credit = 1'b0;
            gap_cnt++;
        end
    endtask

    task automatic read_trace(output bit ok);
        int               fd;
        int               code;
        int               kind;
        int               len;
        int               idx;
        int               gap;
        int               b;
        int               i;
        logic [8*128-1:0] line;
        ok = 1'b0;
        fd = $fopen("tb/udp_tx_trace.txt", "r");
        if (fd != 0) begin
            code = $fgets(line, fd);
            code = $fgets(line, fd);
            code = $fscanf(fd, "%h %h %h %h", kind, len, idx, gap);
            while (code == 4) begin
                t_kind.push_back(kind);
                t_len.push_back(len);
                t_idx.push_back(idx);
                t_gap.push_back(gap);
                t_off.push_back(t_bytes.size());
                for (i = 0; i < len; i++) begin
                    code = $fscanf(fd, "%h", b);
                    t_bytes.push_back(8'(b));
                end
                code = $fscanf(fd, "%h %h %h %h", kind, len, idx, gap);
            end
            $fclose(fd);
            ok = (t_kind.size() > 0);
        end
    endtask

    // First request goes unanswered, the retry gets arp_found
    task automatic connect_test;
        int   pulses;
        int   cyc;
        int   errs0;
        logic prev;
        pulses = 0;
        cyc = 0;
        prev = 1'b0;
        errs0 = errors;
        while (pulses < 2 && cyc < 8 * `UDP_LINK_WAIT) begin
            @(negedge rgmii_clk);
            if (arp_req && !prev) begin
                pulses++;
            end
            prev = arp_req;
            if (connected) begin
                $display("connected went high before any arp_found");
                errors++;
            end
            cyc++;
        end
        check_value("arp_req pulses", pulses, 32'd2);
        repeat (2) @(negedge rgmii_clk);
        arp_found = 1'b1;
        @(negedge rgmii_clk);
        arp_found = 1'b0;
        cyc = 0;
        while (!connected && cyc < 8) begin
            @(negedge rgmii_clk);
            cyc++;
        end
        check_value("connected", 32'(connected), 32'd1);
        repeat (20) @(negedge rgmii_clk);
        check_value("connected", 32'(connected), 32'd1);
        test_cnt++;
        if (errors != errs0) begin
            bad_cnt++;
        end
        $display("test connect, arp_req pulses %0d: %s", pulses,
                 (errors == errs0) ? "ok" : "mismatch");
    endtask

    task automatic run_test(input int k);
        logic [7:0]  exp_q[$];
        logic [79:0] hdr_bits;
        logic [15:0] len16;
        logic [15:0] idx16;
        logic [15:0] lport;
        logic [15:0] dport;
        int          kind;
        int          len;
        int          cyc;
        int          i;
        int          errs0;
        int          reads0;
        int          ovr0;
        bit          done;
        kind = t_kind[k];
        len = t_len[k];
        len16 = 16'(len);
        idx16 = 16'(t_idx[k]);
        lport = `UDP_LOCAL_PORT;
        dport = `UDP_DEST_PORT;
        hdr_bits = {lport, dport, len16 + 16'd10, 16'h0000, idx16};
        for (i = 0; i < 10; i++) begin
            exp_q.push_back(hdr_bits[79 - 8 * i -: 8]);
        end
        src_bytes.delete();
        for (i = 0; i < len; i++) begin
            exp_q.push_back(t_bytes[t_off[k] + i]);
            src_bytes.push_back(t_bytes[t_off[k] + i]);
        end
        src_base = src_taken;
        src_len = len;
        stall_en = (kind == 1);
        errs0 = errors;
        reads0 = read_cnt;
        ovr0 = overrun_cnt;
        trig = 1'b1;
        index = idx16;
        tx_data_len = len16;
        @(negedge rgmii_clk);
        trig = 1'b0;
        done = 1'b0;
        cyc = 0;
        while (!done) begin
            @(negedge rgmii_clk);
            if (out_valid) begin
                delivered++;
                if (delivered > granted) begin
                    $display("test %0d sent more bytes than credits granted", k);
                    errors++;
                end
                if (exp_q.size() == 0) begin
                    $display("test %0d sent an extra byte 0x%02h", k, out_data);
                    errors++;
                end else begin
                    check_value("out_data", 32'(out_data), 32'(exp_q.pop_front()));
                end
                check_value("out_last", 32'(out_last), 32'(exp_q.size() == 0));
                done = out_last;
            end
            grant_credit(t_gap[k]);
            // Busy trigger with different fields, must be ignored
            trig = (kind == 2 && cyc == 4);
            if (trig) begin
                index = ~idx16;
                tx_data_len = len16 + 16'd3;
            end
            cyc++;
        end
        trig = 1'b0;
        if (exp_q.size() != 0) begin
            $display("test %0d frame ended with %0d bytes missing", k, exp_q.size());
            errors++;
        end
        repeat (24) begin
            @(negedge rgmii_clk);
            if (out_valid) begin
                delivered++;
                $display("test %0d output a byte after its frame ended", k);
                errors++;
            end
            grant_credit(t_gap[k]);
        end
        @(negedge rgmii_clk);
        out_credit = 1'b0;
        if (src_taken - src_base != len) begin
            $display("test %0d read %0d of %0d payload bytes", k, src_taken - src_base, len);
            errors++;
        end
        if (overrun_cnt != ovr0) begin
            $display("test %0d requested bytes beyond its payload", k);
            errors++;
        end
        if (len == 0 && read_cnt != reads0) begin
            $display("test %0d raised tx_read_en on a zero-length frame", k);
            errors++;
        end
        test_cnt++;
        if (errors != errs0) begin
            bad_cnt++;
        end
        $display("test %0d kind %0d len %0d gap %0d: %s", k, kind, len, t_gap[k],
                 (errors == errs0) ? "ok" : "mismatch");
    endtask

    initial begin
        arp_rstn = 1'b0;
        trig = 1'b0;
        index = 16'h0000;
        tx_data_len = 16'h0000;
        arp_found = 1'b0;
        out_credit = 1'b0;
        read_trace(trace_ok);
        if (!trace_ok) begin
            $display("the trace file tb/udp_tx_trace.txt could not be read");
            $display("Test failed");
            $finish;
        end else begin
            limit_cycles = 16 * `UDP_LINK_WAIT + 100;
            for (n = 0; n < t_kind.size(); n++) begin
                limit_cycles += (10 + t_len[n]) * (t_gap[n] + 1) * 4 + 40;
            end
            repeat (10) @(negedge rgmii_clk);
            arp_rstn = 1'b1;
            connect_test();
            for (n = 0; n < t_kind.size(); n++) begin
                run_test(n);
            end
            $display("tests %0d, tests with errors %0d, errors %0d, assertion failures %0d",
                     test_cnt, bad_cnt, errors, dut_i.assert_i.assert_fails);
            if (errors == 0 && dut_i.assert_i.assert_fails == 0) begin
                $display("Test completed successfully");
            end else begin
                $display("Test failed");
            end
            $finish;
        end
    end

    initial begin
        wait (limit_cycles > 0);
        repeat (limit_cycles) @(posedge rgmii_clk);
        $display("timeout after %0d cycles, the DUT stopped making progress", limit_cycles);
        $display("Test failed");
        $finish;
    end

endmodule : udp_tx_tb

//--- tb/udp_tx_assert.sv
`timescale 1ns/1ns

module udp_tx_assert (
    input logic rgmii_clk,
    input logic arp_rstn,
    input logic arp_req,
    input logic connected,
    input logic out_valid,
    input logic out_credit
);

    // Output credits granted and not yet used, seen from the ports
    logic [7:0] avail;
    int         assert_fails = 0;

    always_ff @(posedge rgmii_clk or negedge arp_rstn) begin
        if (!arp_rstn) begin
            avail <= '0;
        end else begin
            avail <= avail + {7'd0, out_credit} - {7'd0, out_valid};
        end
    end

    a_out_credit: assert property (@(posedge rgmii_clk) disable iff (!arp_rstn)
        out_valid |-> (avail != 8'd0))
        else begin
            $error("out_valid with no output credit");
            assert_fails++;
        end

    a_arp_pulse: assert property (@(posedge rgmii_clk) disable iff (!arp_rstn)
        $rose(arp_req) |=> !arp_req)
        else begin
            $error("arp_req longer than one cycle");
            assert_fails++;
        end

    a_connected: assert property (@(posedge rgmii_clk) disable iff (!arp_rstn)
        connected |=> connected)
        else begin
            $error("connected fell");
            assert_fails++;
        end

endmodule : udp_tx_assert

bind udp_tx_top udp_tx_assert assert_i (
    .rgmii_clk (rgmii_clk),
    .arp_rstn  (arp_rstn),
    .arp_req   (arp_req),
    .connected (connected),
    .out_valid (out_valid),
    .out_credit(out_credit)
);

//--- design/udp_tx_top.sv
`timescale 1ns/1ns

module udp_tx_top (
    input  logic        rgmii_clk,
    input  logic        arp_rstn,
    input  logic        trig,
    input  logic [15:0] index,
    input  logic [15:0] tx_data_len,
    output logic        tx_read_en,
    input  logic        tx_valid,
    input  logic [7:0]  tx_data,
    output logic        arp_req,
    input  logic        arp_found,
    output logic        connected,
    output logic        out_valid,
    output logic [7:0]  out_data,
    output logic        out_last,
    input  logic        out_credit
);

    logic        frame_start;
    logic        frame_done;
    logic [15:0] frame_len;
    logic [15:0] frame_index;

    udp_byte_if hdr_if ();
    udp_byte_if pay_if ();

    udp_session_ctrl u_session_ctrl (
        .rgmii_clk  (rgmii_clk),
        .arp_rstn   (arp_rstn),
        .trig       (trig),
        .index      (index),
        .tx_data_len(tx_data_len),
        .arp_found  (arp_found),
        .frame_done (frame_done),
        .arp_req    (arp_req),
        .connected  (connected),
        .frame_start(frame_start),
        .frame_len  (frame_len),
        .frame_index(frame_index)
    );

    udp_header_gen u_header_gen (
        .rgmii_clk  (rgmii_clk),
        .arp_rstn   (arp_rstn),
        .frame_start(frame_start),
        .frame_len  (frame_len),
        .hdr        (hdr_if)
    );

    udp_payload_fetch u_payload_fetch (
        .rgmii_clk  (rgmii_clk),
        .arp_rstn   (arp_rstn),
        .frame_start(frame_start),
        .frame_len  (frame_len),
        .frame_index(frame_index),
        .tx_read_en (tx_read_en),
        .tx_valid   (tx_valid),
        .tx_data    (tx_data),
        .pay        (pay_if)
    );

    udp_frame_merge u_frame_merge (
        .rgmii_clk (rgmii_clk),
        .arp_rstn  (arp_rstn),
        .hdr       (hdr_if),
        .pay       (pay_if),
        .out_valid (out_valid),
        .out_data  (out_data),
        .out_last  (out_last),
        .out_credit(out_credit),
        .frame_done(frame_done)
    );

endmodule : udp_tx_top

//--- design/udp_frame_merge.sv
`timescale 1ns/1ns
`include "udp_tx_settings.svh"

module udp_frame_merge
    import udp_tx_pkg::*;
(
    input  logic         rgmii_clk,
    input  logic         arp_rstn,
    udp_byte_if.consumer hdr,
    udp_byte_if.consumer pay,
    output logic         out_valid,
    output logic [7:0]   out_data,
    output logic         out_last,
    input  logic         out_credit,
    output logic         frame_done
);

    localparam int PTR_W  = $clog2(`UDP_CREDIT_MAX);
    localparam int CRED_W = $clog2(`UDP_CREDIT_MAX + 1);
    localparam int CNT_W  = $clog2(`UDP_HDR_BYTES);

    // Per source {last, data}, deep enough for a full credit budget
    logic [8:0]        buf_mem [2][`UDP_CREDIT_MAX];
    logic [PTR_W:0]    wr_ptr [2];
    logic [PTR_W:0]    rd_ptr [2];
    merge_src_e        src;
    logic [CNT_W-1:0]  hdr_cnt;
    logic [CRED_W-1:0] out_cred;
    logic [8:0]        head;
    logic              load;

    assign head = buf_mem[src][rd_ptr[src][PTR_W-1:0]];
    assign load = (out_cred != '0) && (wr_ptr[src] != rd_ptr[src]);

    always_ff @(posedge rgmii_clk) begin
        if (hdr.valid) begin
            buf_mem[SRC_HEADER][wr_ptr[SRC_HEADER][PTR_W-1:0]] <= {hdr.last, hdr.data};
        end
        if (pay.valid) begin
            buf_mem[SRC_PAYLOAD][wr_ptr[SRC_PAYLOAD][PTR_W-1:0]] <= {pay.last, pay.data};
        end
        if (load) begin
            out_data <= head[7:0];
        end
    end

    always_ff @(posedge rgmii_clk or negedge arp_rstn) begin
        if (!arp_rstn) begin
            wr_ptr     <= '{default: '0};
            rd_ptr     <= '{default: '0};
            src        <= SRC_HEADER;
            hdr_cnt    <= '0;
            out_cred   <= '0;
            out_valid  <= 1'b0;
            out_last   <= 1'b0;
            frame_done <= 1'b0;
            hdr.credit <= 1'b0;
            pay.credit <= 1'b0;
        end else begin
            if (hdr.valid) begin
                wr_ptr[SRC_HEADER] <= wr_ptr[SRC_HEADER] + 1'b1;
            end
            if (pay.valid) begin
                wr_ptr[SRC_PAYLOAD] <= wr_ptr[SRC_PAYLOAD] + 1'b1;
            end
            // Credit goes back as the byte appears on the output
            out_valid  <= load;
            out_last   <= load && head[8];
            frame_done <= load && head[8];
            hdr.credit <= load && (src == SRC_HEADER);
            pay.credit <= load && (src == SRC_PAYLOAD);
            if (load) begin
                rd_ptr[src] <= rd_ptr[src] + 1'b1;
                if (src == SRC_HEADER) begin
                    hdr_cnt <= hdr_cnt + 1'b1;
                    if (hdr_cnt == CNT_W'(`UDP_HDR_BYTES - 1)) begin
                        src <= SRC_PAYLOAD;
                    end
                end else if (head[8]) begin
                    src <= SRC_HEADER;
                end
            end
            // Output credits saturate at the ceiling
            if (load && !out_credit) begin
                out_cred <= out_cred - 1'b1;
            end else if (!load && out_credit && out_cred != CRED_W'(`UDP_CREDIT_MAX)) begin
                out_cred <= out_cred + 1'b1;
            end
        end
    end

endmodule : udp_frame_merge

//--- design/udp_payload_fetch.sv
`timescale 1ns/1ns
`include "udp_tx_settings.svh"

module udp_payload_fetch (
    input  logic         rgmii_clk,
    input  logic         arp_rstn,
    input  logic         frame_start,
    input  logic [15:0]  frame_len,
    input  logic [15:0]  frame_index,
    output logic         tx_read_en,
    input  logic         tx_valid,
    input  logic [7:0]   tx_data,
    udp_byte_if.producer pay
);

    localparam int PTR_W  = $clog2(`UDP_FETCH_DEPTH);
    localparam int CRED_W = $clog2(`UDP_CREDIT_MAX + 1);

    logic [7:0]        fifo_mem [`UDP_FETCH_DEPTH];
    logic [PTR_W-1:0]  wr_ptr;
    logic [PTR_W-1:0]  rd_ptr;
    logic [PTR_W:0]    fill;
    logic [15:0]       fetch_left;
    logic [16:0]       send_left;
    logic [CRED_W-1:0] credits;
    logic              take;
    logic              send;

    // Source answers in the cycle of the request
    assign tx_read_en = (fetch_left != '0) && (fill != (PTR_W+1)'(`UDP_FETCH_DEPTH));
    assign take       = tx_read_en && tx_valid;
    assign send       = (fill != '0) && (credits != '0);
    assign pay.valid  = send;
    assign pay.data   = fifo_mem[rd_ptr];
    assign pay.last   = (send_left == 17'd1);

    always_ff @(posedge rgmii_clk or negedge arp_rstn) begin
        if (!arp_rstn) begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            fill       <= '0;
            fetch_left <= '0;
            send_left  <= '0;
            credits    <= CRED_W'(`UDP_CREDIT_MAX);
        end else begin
            if (frame_start) begin
                // Buffer is empty here, index bytes take the first two slots
                wr_ptr     <= PTR_W'(2);
                rd_ptr     <= '0;
                fill       <= (PTR_W+1)'(2);
                fetch_left <= frame_len;
                send_left  <= {1'b0, frame_len} + 17'd2;
            end else begin
                if (take) begin
                    wr_ptr     <= wr_ptr + 1'b1;
                    fetch_left <= fetch_left - 1'b1;
                end
                if (send) begin
                    rd_ptr    <= rd_ptr + 1'b1;
                    send_left <= send_left - 1'b1;
                end
                case ({take, send})
                    2'b10:   fill <= fill + 1'b1;
                    2'b01:   fill <= fill - 1'b1;
                    default: fill <= fill;
                endcase
            end
            case ({send, pay.credit})
                2'b10:   credits <= credits - 1'b1;
                2'b01:   credits <= credits + 1'b1;
                default: credits <= credits;
            endcase
        end
    end

    always_ff @(posedge rgmii_clk) begin
        if (frame_start) begin
            fifo_mem[0] <= frame_index[15:8];
            fifo_mem[1] <= frame_index[7:0];
        end else if (take) begin
            fifo_mem[wr_ptr] <= tx_data;
        end
    end

endmodule : udp_payload_fetch

//--- design/udp_header_gen.sv
`timescale 1ns/1ns
`include "udp_tx_settings.svh"

module udp_header_gen (
    input  logic         rgmii_clk,
    input  logic         arp_rstn,
    input  logic         frame_start,
    input  logic [15:0]  frame_len,
    udp_byte_if.producer hdr
);

    localparam int CNT_W  = $clog2(`UDP_HDR_BYTES);
    localparam int CRED_W = $clog2(`UDP_CREDIT_MAX + 1);

    localparam logic [15:0] LOCAL_PORT = `UDP_LOCAL_PORT;
    localparam logic [15:0] DEST_PORT  = `UDP_DEST_PORT;

    logic              active;
    logic [CNT_W-1:0]  byte_cnt;
    logic [CRED_W-1:0] credits;
    logic [15:0]       udp_len;
    logic              send;

    // Header, index and payload
    assign udp_len   = frame_len + 16'd10;
    assign send      = active && (credits != '0);
    assign hdr.valid = send;
    assign hdr.last  = 1'b0;

    always_comb begin
        case (byte_cnt)
            0:       hdr.data = LOCAL_PORT[15:8];
            1:       hdr.data = LOCAL_PORT[7:0];
            2:       hdr.data = DEST_PORT[15:8];
            3:       hdr.data = DEST_PORT[7:0];
            4:       hdr.data = udp_len[15:8];
            5:       hdr.data = udp_len[7:0];
            default: hdr.data = 8'h00; // checksum unused
        endcase
    end

    always_ff @(posedge rgmii_clk or negedge arp_rstn) begin
        if (!arp_rstn) begin
            active   <= 1'b0;
            byte_cnt <= '0;
            credits  <= CRED_W'(`UDP_CREDIT_MAX);
        end else begin
            if (frame_start) begin
                active   <= 1'b1;
                byte_cnt <= '0;
            end else if (send) begin
                byte_cnt <= byte_cnt + 1'b1;
                if (byte_cnt == CNT_W'(`UDP_HDR_BYTES - 1)) begin
                    active <= 1'b0;
                end
            end
            case ({send, hdr.credit})
                2'b10:   credits <= credits - 1'b1;
                2'b01:   credits <= credits + 1'b1;
                default: credits <= credits;
            endcase
        end
    end

endmodule : udp_header_gen

//--- design/udp_session_ctrl.sv
`timescale 1ns/1ns
`include "udp_tx_settings.svh"

module udp_session_ctrl
    import udp_tx_pkg::*;
(
    input  logic        rgmii_clk,
    input  logic        arp_rstn,
    input  logic        trig,
    input  logic [15:0] index,
    input  logic [15:0] tx_data_len,
    input  logic        arp_found,
    input  logic        frame_done,
    output logic        arp_req,
    output logic        connected,
    output logic        frame_start,
    output logic [15:0] frame_len,
    output logic [15:0] frame_index
);

    localparam int WAIT_W = $clog2(`UDP_LINK_WAIT);

    session_state_e    state;
    logic [WAIT_W-1:0] wait_cnt;
    logic              wait_done;

    // Same counter for the settle wait and the ARP timeout
    assign wait_done = (wait_cnt == WAIT_W'(`UDP_LINK_WAIT - 1));
    assign arp_req   = (state == ARP_REQ);

    always_ff @(posedge rgmii_clk or negedge arp_rstn) begin
        if (!arp_rstn) begin
            state       <= LINK_WAIT;
            wait_cnt    <= '0;
            connected   <= 1'b0;
            frame_start <= 1'b0;
        end else begin
            frame_start <= 1'b0;
            case (state)
                LINK_WAIT: begin
                    if (wait_done) begin
                        wait_cnt <= '0;
                        state    <= ARP_REQ;
                    end else begin
                        wait_cnt <= wait_cnt + 1'b1;
                    end
                end
                ARP_REQ: begin
                    state <= ARP_WAIT;
                end
                ARP_WAIT: begin
                    if (arp_found) begin
                        wait_cnt  <= '0;
                        connected <= 1'b1;
                        state     <= IDLE;
                    end else if (wait_done) begin
                        // No answer, settle again and retry
                        wait_cnt <= '0;
                        state    <= LINK_WAIT;
                    end else begin
                        wait_cnt <= wait_cnt + 1'b1;
                    end
                end
                IDLE: begin
                    if (trig) begin
                        frame_start <= 1'b1;
                        state       <= SENDING;
                    end
                end
                SENDING: begin
                    // trig is ignored until the merger reports the end
                    if (frame_done) begin
                        state <= IDLE;
                    end
                end
                default: begin
                    state <= LINK_WAIT;
                end
            endcase
        end
    end

    // Held stable for the whole frame
    always_ff @(posedge rgmii_clk) begin
        if (state == IDLE && trig) begin
            frame_len   <= tx_data_len;
            frame_index <= index;
        end
    end

endmodule : udp_session_ctrl

//--- design/udp_byte_if.sv
`timescale 1ns/1ns

interface udp_byte_if;

    logic       valid;
    logic [7:0] data;
    logic       last;
    // One pulse hands one credit back to the producer
    logic       credit;

    modport producer (
        output valid,
        output data,
        output last,
        input  credit
    );

    modport consumer (
        input  valid,
        input  data,
        input  last,
        output credit
    );

endinterface : udp_byte_if

//--- design/udp_tx_pkg.sv
package udp_tx_pkg;

    // Session controller states
    typedef enum logic [2:0] {
        LINK_WAIT,
        ARP_REQ,
        ARP_WAIT,
        IDLE,
        SENDING
    } session_state_e;

    // Stream the merger is forwarding
    typedef enum logic {
        SRC_HEADER,
        SRC_PAYLOAD
    } merge_src_e;

endpackage : udp_tx_pkg

//--- include/udp_tx_settings.svh
`ifndef UDP_TX_SETTINGS_SVH
`define UDP_TX_SETTINGS_SVH

// UDP port numbers placed in every header
`define UDP_LOCAL_PORT  16'h8080
`define UDP_DEST_PORT   16'h8081

// Settle wait and ARP timeout, in rgmii_clk cycles
// 200 ms at 125 MHz on the board is 25_000_000
`define UDP_LINK_WAIT   64

// Credits held by each producer, and the output credit ceiling
`define UDP_CREDIT_MAX  8

// Payload buffer entries, power of two
`define UDP_FETCH_DEPTH 4

`define UDP_HDR_BYTES   8

`endif
